//--- Makefile
# Verilator build and run for the dual-issue front end

VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= dual_issue_frontend.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
	  echo "Simulation reported failures"; exit 1; \
	fi
	@if ! grep -q "All tests passed!" $(LOG); then \
	  echo "Simulation did not finish cleanly"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dual_issue_frontend.f
verilog/frontend_pkg.sv
verilog/fetch_unit.sv
verilog/dispatch_buffer.sv
verilog/dispatch_unit.sv
verilog/dual_issue_frontend.sv
sim/imem_model.sv
sim/frontend_tb.sv

//--- sim/frontend_tb.sv
// Testbench for the dual-issue front end
// Directed tests for reset, program order, dependencies, pair
// compaction, the zero register and halt

`timescale 1ns/1ps

module frontend_tb;
  import frontend_pkg::*;

  localparam int MEM_WORDS  = 64;
  localparam int WAIT_LIMIT = 600;      // Cycles per wait loop

  logic        clock = 1'b0;
  logic        reset = 1'b1;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  completion_t complete = '0;
  inst_pair_t  dispatch_out;
  logic [3:0]  status;

  logic [ILEN-1:0]    program_words[$];
  logic [ILEN-1:0]    seen_ir[$];
  logic [XLEN-1:0]    seen_npc[$];
  int unsigned        seen_edge[$];
  logic [REG_IDX-1:0] pending_regs[$];
  int                 seen_base;
  logic               auto_complete = 1'b0;
  logic [REG_IDX-1:0] manual_reg = '0;
  int unsigned        manual_requests = 0;
  int unsigned        manual_served = 0;
  int unsigned        last_complete_edge = 0;
  int unsigned        cycle_count = 0;
  int                 test_errors;
  int                 error_count;
  int                 tests_run;
  int                 tests_failed;

  dual_issue_frontend dual_issue_frontend_i (
    .clock        (clock),
    .reset        (reset),
    .mem_req      (mem_req),
    .mem_rsp      (mem_rsp),
    .complete     (complete),
    .dispatch_out (dispatch_out),
    .status       (status)
  );

  imem_model #(.WORDS(MEM_WORDS)) imem_i (
    .clock   (clock),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  always #20 clock = ~clock;

  //////////////////////////////////////////////////
  // Dispatch monitor and completion driver
  //////////////////////////////////////////////////

  always @(posedge clock) begin
    decoded_inst_t d;
    cycle_count <= cycle_count + 1;
    if (reset) begin
      pending_regs.delete();
      complete <= '0;
    end else begin
      complete <= '0;
      if (manual_requests != manual_served) begin
        complete           <= {1'b1, manual_reg};
        manual_served      <= manual_requests;
        last_complete_edge <= cycle_count;
      end else if (auto_complete && pending_regs.size() > 0) begin
        complete <= {1'b1, pending_regs.pop_front()};
      end
      for (int s = 0; s < 2; s++) begin
        if (dispatch_out[s].valid) begin
          seen_ir.push_back(dispatch_out[s].ir);
          seen_npc.push_back(dispatch_out[s].npc);
          seen_edge.push_back(cycle_count);
          check_flags(dispatch_out[s]);
          d = decode_inst(dispatch_out[s].ir, dispatch_out[s].npc);
          if (auto_complete && d.writes_rc && d.rc != ZERO_REG) begin
            pending_regs.push_back(d.rc);   // Freed one cycle later
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Operate format reading ra and rb and writing rc
  function automatic logic [ILEN-1:0] op_inst(input logic [4:0] ra, input logic [4:0] rb,
                                              input logic [4:0] rc);
    return {4'h4, 2'b00, ra, rb, 11'h000, rc};
  endfunction

  // Non-operate format reading ra only
  function automatic logic [ILEN-1:0] other_inst(input logic [4:0] ra);
    return {6'h08, ra, 5'd31, 16'h0000};
  endfunction

  function automatic int expected_count();
    for (int i = 0; i < program_words.size(); i++) begin
      if (program_words[i] == 32'h0) begin
        return i + 1;
      end
    end
    return program_words.size();
  endfunction

  function automatic int seen_count();
    return seen_ir.size() - seen_base;
  endfunction

  task automatic report_value(input string name, input logic [63:0] exp_v,
                              input logic [63:0] got_v);
    $display("Error: %s expected %h got %h", name, exp_v, got_v);
    test_errors++;
    error_count++;
  endtask

  task automatic report_problem(input string what);
    $display("Failure: %s", what);
    test_errors++;
    error_count++;
  endtask

  // Operand use flags {uses_ra, uses_rb, writes_rc, halt} of a dispatched slot
  task automatic check_flags(input decoded_inst_t got);
    logic [3:0] exp_flags;
    logic [3:0] got_flags;
    if (got.ir == 32'h0) begin
      exp_flags = 4'b0001;                  // Halt touches no register
    end else if (got.ir[31:26] >= 6'h10 && got.ir[31:26] <= 6'h13) begin
      exp_flags = 4'b1110;
    end else begin
      exp_flags = 4'b1000;
    end
    got_flags = {got.uses_ra, got.uses_rb, got.writes_rc, got.halt};
    if (got_flags != exp_flags) begin
      report_value("dispatch_out operand flags", 64'(exp_flags), 64'(got_flags));
    end
  endtask

  task automatic check_idle();
    if (mem_req.command != BUS_NONE) begin
      report_value("mem_req.command", 64'(BUS_NONE), 64'(mem_req.command));
    end
    if (dispatch_out[0].valid || dispatch_out[1].valid) begin
      report_value("dispatch_out valid bits", 64'h0,
                   64'({dispatch_out[1].valid, dispatch_out[0].valid}));
    end
    if (status != NO_ERROR) begin
      report_value("status", 64'(NO_ERROR), 64'(status));
    end
  endtask

  task automatic reset_dut(input bit check);
    @(posedge clock);
    reset <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      @(negedge clock);
      if (check && i > 0) begin
        check_idle();
      end
      @(posedge clock);
    end
    reset <= 1'b0;
    @(negedge clock);
    if (check) begin
      check_idle();              // First cycle out of reset
    end
    seen_base = seen_ir.size();
  endtask

  task automatic start_test(input bit auto_mode, input bit check_reset);
    test_errors = 0;
    tests_run++;
    auto_complete = auto_mode;
    for (int k = 0; k < MEM_WORDS; k++) begin
      imem_i.mem[k] = {32'h23ff_8000 | 32'(k), 32'h23ff_0000 | 32'(k)};
    end
    for (int w = 0; w < program_words.size() / 2; w++) begin
      imem_i.mem[w] = {program_words[2*w+1], program_words[2*w]};
    end
    reset_dut(check_reset);
  endtask

  task automatic finish_test(input string name);
    if (test_errors != 0) begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", name, test_errors);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  task automatic settle(input int cycles);
    repeat (cycles) @(negedge clock);
  endtask

  task automatic wait_for_count(input int n);
    int waited;
    waited = 0;
    while (seen_count() < n && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    if (seen_count() < n) begin
      report_problem($sformatf("timed out waiting for %0d dispatches, saw %0d",
                               n, seen_count()));
    end
  endtask

  // Present one completion and return the edge where it was driven
  task automatic present_completion(input logic [4:0] r, output int unsigned edge_num);
    int waited;
    waited = 0;
    @(negedge clock);
    manual_reg = r;
    manual_requests++;
    while (manual_served != manual_requests && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    if (manual_served != manual_requests) begin
      report_problem("completion was never driven");
    end
    edge_num = last_complete_edge;
  endtask

  task automatic check_sequence(input int n);
    int limit;
    if (seen_count() != n) begin
      report_value("dispatch count", 64'(n), 64'(seen_count()));
    end
    limit = (seen_count() < n) ? seen_count() : n;
    for (int i = 0; i < limit; i++) begin
      if (seen_ir[seen_base+i] != program_words[i]) begin
        report_value($sformatf("dispatch_out.ir[%0d]", i), 64'(program_words[i]),
                     64'(seen_ir[seen_base+i]));
      end
      if (seen_npc[seen_base+i] != 64'((i + 1) * 4)) begin
        report_value($sformatf("dispatch_out.npc[%0d]", i), 64'((i + 1) * 4),
                     seen_npc[seen_base+i]);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset_state();
    program_words = {other_inst(5'd31), 32'h0};
    start_test(1'b1, 1'b1);
    finish_test("reset_state");
  endtask

  task automatic test_program_order();
    program_words.delete();
    for (int k = 0; k < 24; k++) begin
      if (k % 2 == 0) begin
        program_words.push_back(op_inst(5'd31, 5'd31, 5'(k / 2 + 1)));
      end else if (k % 4 == 1) begin
        program_words.push_back(other_inst(5'd31));
      end else begin
        program_words.push_back(op_inst(5'd31, 5'd31, 5'd31));
      end
    end
    program_words.push_back(32'h0);
    program_words.push_back(32'h0);
    start_test(1'b1, 1'b0);
    wait_for_count(expected_count());
    settle(20);                             // Nothing may follow the halt
    check_sequence(expected_count());
    finish_test("program_order");
  endtask

  task automatic test_dependency();
    int unsigned done_edge;
    program_words = {op_inst(5'd31, 5'd31, 5'd5), other_inst(5'd31),
                     op_inst(5'd5, 5'd31, 5'd6), other_inst(5'd31), 32'h0, 32'h0};
    start_test(1'b0, 1'b0);
    wait_for_count(2);
    settle(12);
    if (seen_count() != 2) begin
      report_problem("reader of r5 or a younger instruction went before the completion");
    end
    present_completion(5'd5, done_edge);
    wait_for_count(expected_count());
    if (seen_count() >= 3 && seen_edge[seen_base+2] < done_edge + 2) begin
      report_problem("reader of r5 dispatched too early after completion");
    end
    check_sequence(expected_count());
    finish_test("dependency_wait");
  endtask

  task automatic test_compaction();
    program_words = {op_inst(5'd31, 5'd31, 5'd7), op_inst(5'd7, 5'd31, 5'd8),
                     other_inst(5'd31), other_inst(5'd31), 32'h0, 32'h0};
    start_test(1'b1, 1'b0);
    wait_for_count(expected_count());
    settle(10);
    if (seen_count() >= 2 && seen_edge[seen_base+1] <= seen_edge[seen_base]) begin
      report_problem("dependent slot 1 dispatched together with slot 0");
    end
    check_sequence(expected_count());
    finish_test("pair_compaction");
  endtask

  task automatic test_zero_register();
    program_words.delete();
    for (int k = 0; k < 5; k++) begin
      program_words.push_back(op_inst(5'd31, 5'd31, 5'd31));
      program_words.push_back(other_inst(5'd31));
    end
    program_words.push_back(32'h0);
    program_words.push_back(32'h0);
    start_test(1'b0, 1'b0);                 // No completions at all
    wait_for_count(expected_count());
    settle(10);
    check_sequence(expected_count());
    finish_test("zero_register");
  endtask

  task automatic test_halt();
    int waited;
    int loads;
    program_words = {other_inst(5'd31), 32'h0, op_inst(5'd31, 5'd31, 5'd3),
                     other_inst(5'd31), other_inst(5'd31), other_inst(5'd31)};
    start_test(1'b1, 1'b0);
    waited = 0;
    while (status != HALTED_ON_HALT && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    if (status != HALTED_ON_HALT) begin
      report_value("status", 64'(HALTED_ON_HALT), 64'(status));
    end
    settle(2);                              // A load already on the bus may finish
    loads = 0;
    for (int i = 0; i < 40; i++) begin
      @(negedge clock);
      if (mem_req.command == BUS_LOAD) begin
        loads++;
      end
    end
    if (loads != 0) begin
      report_problem("fetch issued a load after the halt");
    end
    check_sequence(expected_count());
    finish_test("halt");
  endtask

  initial begin
    void'($urandom(32'h7d9a));
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    seen_base    = 0;
    test_reset_state();
    test_program_order();
    test_dependency();
    test_compaction();
    test_zero_register();
    test_halt();
    $display("Tests run: %0d, failed: %0d, error lines: %0d",
             tests_run, tests_failed, error_count);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- sim/imem_model.sv
// Instruction memory model for the front end testbench
// Accepts loads with a nonzero tag or a zero retry, then returns
// the tagged word after a random latency of 1 to 6 cycles

`timescale 1ns/1ps

module imem_model #(
  parameter int WORDS = 64
) (
  input  logic                   clock,
  input  logic                   reset,
  input  frontend_pkg::mem_req_t mem_req,
  output frontend_pkg::mem_rsp_t mem_rsp
);
  import frontend_pkg::*;

  logic [XLEN-1:0]  mem [0:WORDS-1];   // Filled by the testbench
  logic             busy;
  int unsigned      delay;
  logic [TAG_W-1:0] next_tag;
  logic [TAG_W-1:0] held_tag;
  logic [XLEN-1:0]  held_addr;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_rsp  <= '0;
      busy     <= 1'b0;
      delay    <= 0;
      next_tag <= 4'd1;
    end else begin
      mem_rsp.tag  <= '0;
      mem_rsp.data <= '0;
      if (busy) begin
        mem_rsp.response <= '0;
        if (delay == 0) begin
          mem_rsp.tag  <= held_tag;
          mem_rsp.data <= mem[held_addr[3 +: $clog2(WORDS)]];
          busy         <= 1'b0;
        end else begin
          delay <= delay - 1;
        end
      end else if (mem_req.command == BUS_LOAD && mem_rsp.response != '0) begin
        busy             <= 1'b1;          // Request accepted with this tag
        held_tag         <= mem_rsp.response;
        held_addr        <= mem_req.addr;
        delay            <= $urandom_range(5, 0);
        mem_rsp.response <= '0;
        next_tag         <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end else begin
        // One offer in four is a retry
        mem_rsp.response <= ($urandom_range(3, 0) == 0) ? '0 : next_tag;
      end
    end
  end

endmodule

//--- verilog/dispatch_buffer.sv
// Two-slot ID/dispatch register
// Loads a fresh pair once every valid slot is taken, and moves
// slot 1 down into slot 0 when only the older slot dispatches

`timescale 1ns/1ps

module dispatch_buffer (
  input  logic                     clock,
  input  logic                     reset,
  input  frontend_pkg::inst_pair_t fetch_pair,
  input  logic                     fetch_valid,
  output logic                     fetch_stall,
  output frontend_pkg::inst_pair_t slots,
  input  logic [1:0]               take
);
  import frontend_pkg::*;

  decoded_inst_t noop_slot;
  logic          all_taken;
  logic          pair_moves;

  // Empty slot contents after reset
  always_comb begin
    noop_slot       = decode_inst(NOOP_INST, '0);
    noop_slot.valid = 1'b0;
  end

  // Buffer is free for a new pair when no valid slot stays behind
  assign all_taken   = (take[0] || !slots[0].valid) && (take[1] || !slots[1].valid);
  assign fetch_stall = !all_taken;
  assign pair_moves  = fetch_valid && all_taken;

  //////////////////////////////////////////////////
  // Load, shift and hold
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      slots <= {noop_slot, noop_slot};
    end else if (all_taken) begin
      if (pair_moves) begin
        slots <= fetch_pair;
      end else begin
        slots[0].valid <= 1'b0;       // Drained with nothing arriving
        slots[1].valid <= 1'b0;
      end
    end else if (take[0]) begin
      // Younger slot moves down behind the dispatched one
      slots[0]       <= slots[1];
      slots[1].valid <= 1'b0;
    end
  end

  take_in_order: assert property (
    @(posedge clock) disable iff (reset)
    take[1] |-> take[0]
  ) else $error("slot 1 taken without slot 0");

  slots_compact: assert property (
    @(posedge clock) disable iff (reset)
    slots[1].valid |-> slots[0].valid
  ) else $error("slot 1 valid while slot 0 is empty");

endmodule

//--- verilog/dispatch_unit.sv
// In-order dispatch with a register busy scoreboard
// A slot leaves once its operands and destination are free;
// completions clear busy bits, a halt freezes dispatch

`timescale 1ns/1ps

module dispatch_unit (
  input  logic                      clock,
  input  logic                      reset,
  input  frontend_pkg::inst_pair_t  slots,
  input  frontend_pkg::completion_t complete,
  output logic [1:0]                take,
  output frontend_pkg::inst_pair_t  dispatch_out,
  output logic                      halted,
  output logic [3:0]                status
);
  import frontend_pkg::*;

  logic [NUM_REGS-1:0] busy;
  logic [1:0]          regs_free;
  logic                pair_conflict;
  logic                halt_issued;

  // True when nothing the slot touches is still in flight
  function automatic logic operands_free(input decoded_inst_t d,
                                         input logic [NUM_REGS-1:0] busy_v);
    return !(d.uses_ra && busy_v[d.ra]) &&
           !(d.uses_rb && busy_v[d.rb]) &&
           !(d.writes_rc && busy_v[d.rc]);
  endfunction

  //////////////////////////////////////////////////
  // Dispatch decision
  //////////////////////////////////////////////////

  assign regs_free[0] = operands_free(slots[0], busy);
  assign regs_free[1] = operands_free(slots[1], busy);

  // Younger slot touching the older one's destination waits a cycle
  assign pair_conflict = slots[0].writes_rc && (slots[0].rc != ZERO_REG) &&
                         ((slots[1].uses_ra && slots[1].ra == slots[0].rc) ||
                          (slots[1].uses_rb && slots[1].rb == slots[0].rc) ||
                          (slots[1].writes_rc && slots[1].rc == slots[0].rc));

  assign take[0] = slots[0].valid && !halted && regs_free[0];
  assign take[1] = take[0] && slots[1].valid && regs_free[1] &&
                   !slots[0].halt && !pair_conflict;

  assign halt_issued = (take[0] && slots[0].halt) || (take[1] && slots[1].halt);

  always_comb begin
    dispatch_out          = slots;
    dispatch_out[0].valid = take[0];
    dispatch_out[1].valid = take[1];
  end

  //////////////////////////////////////////////////
  // Scoreboard and halt status
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (complete.valid) begin
        busy[complete.reg_idx] <= 1'b0;
      end
      for (int i = 0; i < 2; i++) begin
        if (take[i] && slots[i].writes_rc && slots[i].rc != ZERO_REG) begin
          busy[slots[i].rc] <= 1'b1;    // Set wins over a same-cycle clear
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (halt_issued) begin
      halted <= 1'b1;                   // Sticky until reset
    end
  end

  assign status = halted ? HALTED_ON_HALT : NO_ERROR;

  // Completions only come back for registers an earlier dispatch marked
  complete_was_busy: assert property (
    @(posedge clock) disable iff (reset)
    complete.valid |-> busy[complete.reg_idx]
  ) else $error("completion for register %0d which is not busy", complete.reg_idx);

endmodule

//--- verilog/dual_issue_frontend.sv
// Two-wide in-order front end
// Fetch feeds the two-slot dispatch buffer, the dispatch unit
// drains it against the register scoreboard

`timescale 1ns/1ps

module dual_issue_frontend (
  input  logic                      clock,
  input  logic                      reset,
  output frontend_pkg::mem_req_t    mem_req,
  input  frontend_pkg::mem_rsp_t    mem_rsp,
  input  frontend_pkg::completion_t complete,
  output frontend_pkg::inst_pair_t  dispatch_out,
  output logic [3:0]                status
);
  import frontend_pkg::*;

  inst_pair_t fetch_pair;
  inst_pair_t slots;
  logic       fetch_valid;
  logic       fetch_stall;
  logic [1:0] take;
  logic       halted;       // Stops fetch requests after a halt

  fetch_unit fetch_unit_i (
    .clock       (clock),
    .reset       (reset),
    .mem_req     (mem_req),
    .mem_rsp     (mem_rsp),
    .halted      (halted),
    .fetch_stall (fetch_stall),
    .fetch_valid (fetch_valid),
    .fetch_pair  (fetch_pair)
  );

  dispatch_buffer dispatch_buffer_i (
    .clock       (clock),
    .reset       (reset),
    .fetch_pair  (fetch_pair),
    .fetch_valid (fetch_valid),
    .fetch_stall (fetch_stall),
    .slots       (slots),
    .take        (take)
  );

  dispatch_unit dispatch_unit_i (
    .clock        (clock),
    .reset        (reset),
    .slots        (slots),
    .complete     (complete),
    .take         (take),
    .dispatch_out (dispatch_out),
    .halted       (halted),
    .status       (status)
  );

endmodule

//--- verilog/fetch_unit.sv
// Instruction fetch
// Issues one tagged load per 64-bit word, waits for the matching
// reply, decodes both halves and holds the pair until the
// dispatch buffer accepts it

`timescale 1ns/1ps

module fetch_unit (
  input  logic                     clock,
  input  logic                     reset,
  output frontend_pkg::mem_req_t   mem_req,
  input  frontend_pkg::mem_rsp_t   mem_rsp,
  input  logic                     halted,
  input  logic                     fetch_stall,
  output logic                     fetch_valid,
  output frontend_pkg::inst_pair_t fetch_pair
);
  import frontend_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,       // Load on the bus until a nonzero response
    WAIT_DATA,     // Accepted, waiting for the tagged reply
    HOLD           // Decoded pair offered to the buffer
  } fetch_state_t;

  fetch_state_t     state;
  logic [XLEN-1:0]  pc;
  logic [TAG_W-1:0] pending_tag;
  logic             reply_hit;
  logic             pair_moves;

  assign reply_hit  = (state == WAIT_DATA) && (pending_tag != '0) &&
                      (mem_rsp.tag == pending_tag);
  assign fetch_valid = (state == HOLD);
  assign pair_moves  = fetch_valid && !fetch_stall;

  always_comb begin
    mem_req.command = (state == REQUEST) ? BUS_LOAD : BUS_NONE;
    mem_req.addr    = {pc[XLEN-1:3], 3'b000};     // Word aligned
  end

  //////////////////////////////////////////////////
  // Request FSM and PC
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= IDLE;
      pc          <= '0;
      pending_tag <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (!halted) begin
            state <= REQUEST;
          end
        end
        REQUEST: begin
          if (halted) begin
            state <= IDLE;
          end else if (mem_rsp.response != '0) begin
            pending_tag <= mem_rsp.response;   // Zero response means retry
            state       <= WAIT_DATA;
          end
        end
        WAIT_DATA: begin
          if (reply_hit) begin
            pc          <= pc + FETCH_STRIDE;
            pending_tag <= '0;
            state       <= HOLD;
          end
        end
        HOLD: begin
          if (pair_moves) begin
            state <= halted ? IDLE : REQUEST;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Low half is the older instruction
  always_ff @(posedge clock) begin
    if (reply_hit) begin
      fetch_pair[0] <= decode_inst(mem_rsp.data[ILEN-1:0], pc + XLEN'(ILEN / 8));
      fetch_pair[1] <= decode_inst(mem_rsp.data[XLEN-1:ILEN], pc + FETCH_STRIDE);
    end
  end

  // A pending load is repeated unchanged until accepted
  req_stable_until_accept: assert property (
    @(posedge clock) disable iff (reset || halted)
    (mem_req.command == BUS_LOAD && mem_rsp.response == '0) |=> $stable(mem_req)
  ) else $error("fetch request changed before it was accepted");

endmodule

//--- verilog/frontend_pkg.sv
// Shared definitions for the two-wide instruction front end
// Memory bus encodings, slot and pair structs, completion bus
// and the instruction decode used by fetch

package frontend_pkg;

  localparam int XLEN     = 64;              // Address and data width
  localparam int ILEN     = 32;              // Instruction width
  localparam int REG_IDX  = 5;
  localparam int NUM_REGS = 32;
  localparam int TAG_W    = 4;               // Memory transaction tag

  localparam logic [REG_IDX-1:0] ZERO_REG = 5'd31;

  // Memory commands
  localparam logic [1:0] BUS_NONE = 2'h0;
  localparam logic [1:0] BUS_LOAD = 2'h1;

  localparam logic [XLEN-1:0] FETCH_STRIDE = 64'd8;   // Two instructions per word

  localparam logic [ILEN-1:0] NOOP_INST = 32'h47ff041f;
  localparam logic [ILEN-1:0] HALT_INST = 32'h0000_0000;

  // Status codes
  localparam logic [3:0] NO_ERROR       = 4'h0;
  localparam logic [3:0] HALTED_ON_HALT = 4'h2;

  // Opcodes 0x10 to 0x13 share the top four opcode bits
  localparam logic [3:0] OPERATE_OPCODES = 4'h4;

  typedef struct packed {
    logic [1:0]      command;
    logic [XLEN-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [TAG_W-1:0] response;      // Nonzero when the request is accepted
    logic [TAG_W-1:0] tag;           // Tag of the data on this cycle
    logic [XLEN-1:0]  data;
  } mem_rsp_t;

  typedef struct packed {
    logic               valid;
    logic [XLEN-1:0]    npc;
    logic [ILEN-1:0]    ir;
    logic [REG_IDX-1:0] ra;
    logic [REG_IDX-1:0] rb;
    logic [REG_IDX-1:0] rc;
    logic               uses_ra;
    logic               uses_rb;
    logic               writes_rc;
    logic               halt;
  } decoded_inst_t;

  // Index 0 is the older instruction
  typedef decoded_inst_t [1:0] inst_pair_t;

  typedef struct packed {
    logic               valid;
    logic [REG_IDX-1:0] reg_idx;
  } completion_t;

  function automatic decoded_inst_t decode_inst(input logic [ILEN-1:0] inst,
                                                input logic [XLEN-1:0] npc);
    decoded_inst_t d;
    d       = '0;
    d.valid = 1'b1;
    d.npc   = npc;
    d.ir    = inst;
    d.ra    = inst[25:21];
    d.rb    = inst[20:16];
    d.rc    = inst[4:0];
    if (inst == HALT_INST) begin
      d.halt = 1'b1;                 // No register operands
    end else if (inst[31:28] == OPERATE_OPCODES) begin
      d.uses_ra   = 1'b1;
      d.uses_rb   = 1'b1;
      d.writes_rc = 1'b1;
    end else begin
      d.uses_ra = 1'b1;
    end
    return d;
  endfunction

endpackage
